/* common/cr16_pkg.sv */
// cr16 shared definitions
`default_nettype none

package cr16_pkg;

    // alu operation codes, shared by opcode and ext fields
    typedef enum logic [3:0] {
        ALU_NOP  = 4'b0000,
        ALU_AND  = 4'b0001,
        ALU_OR   = 4'b0010,
        ALU_XOR  = 4'b0011,
        ALU_LSH  = 4'b0100,
        ALU_ADD  = 4'b0101,
        ALU_ADDU = 4'b0110,
        ALU_ADDC = 4'b0111,
        ALU_NOT  = 4'b1000,
        ALU_SUB  = 4'b1001,
        ALU_SUBC = 4'b1010,
        ALU_CMP  = 4'b1011,
        ALU_ASHU = 4'b1100,
        ALU_MOV  = 4'b1101
    } alu_op_t;

    localparam logic [3:0] OPC_REG  = 4'b0000; // register class, ext picks the op
    localparam logic [3:0] OPC_HALT = 4'b1111;
    localparam logic [3:0] EXT_LOAD = 4'b1110; // rd <= mem[rs]
    localparam logic [3:0] EXT_STOR = 4'b1111; // mem[rs] <= rd

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] rd;
        logic [3:0] ext;
        logic [3:0] rs;
    } instr_reg_t;

    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] rd;
        logic [7:0] imm;      // sign extended to 16 bits on use
    } instr_imm_t;

    // one fetched word, read either way
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_t;

    typedef struct packed {
        logic z;              // equal
        logic l;              // unsigned below
        logic n;              // signed below
        logic c;              // carry / borrow
        logic f;              // signed overflow
    } flags_t;

    typedef struct packed {
        logic        en;
        logic        we;
        logic [9:0]  addr;
        logic [15:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [9:0]  paddr;   // word address
        logic [15:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [15:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam logic [9:0] MEM_TOP   = 10'h1FF; // end of memory window
    localparam logic [9:0] CTRL_ADDR = 10'h200; // w: bit0 start, r: {flags, running}
    localparam logic [9:0] REGS_BASE = 10'h300; // general registers, read only
    localparam logic [9:0] REGS_LAST = 10'h30F;

endpackage

`default_nettype wire

/* control/cr16_control.sv */
// cr16 control and decode FSM
`timescale 1ns/1ns
`default_nettype none

module cr16_control #(
    parameter int MEM_AW = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    output logic                halted,
    output cr16_pkg::mem_req_t  core_mem,
    input  logic [15:0]         mem_rdata,
    output logic [3:0]          ra_idx,
    output logic [3:0]          rb_idx,
    input  logic [15:0]         rdata_a,
    input  logic [15:0]         rdata_b,
    output logic                reg_we,
    output logic [3:0]          reg_widx,
    output logic [15:0]         reg_wdata,
    output cr16_pkg::alu_op_t   alu_op,
    output logic [15:0]         alu_a,
    output logic [15:0]         alu_b,
    output logic                alu_go,
    input  logic [15:0]         alu_result
);
    import cr16_pkg::*;

    typedef enum logic [2:0] {S0, S1, S2, S3, S4, S5, S_HALT} state_t;

    state_t            state;
    state_t            next_state;
    logic [MEM_AW-1:0] pc;
    instr_t            ir;            // held instruction
    instr_t            fetched;       // word arriving in S1
    logic              is_reg_form;
    logic [3:0]        op_code;
    logic [15:0]       imm_sext;
    logic [9:0]        data_addr;     // load/store address from rs

    assign fetched     = mem_rdata;
    assign is_reg_form = (ir.r.opcode == OPC_REG);
    assign op_code     = is_reg_form ? ir.r.ext : ir.r.opcode;
    assign imm_sext    = {{8{ir.i.imm[7]}}, ir.i.imm};
    assign data_addr   = {{(10-MEM_AW){1'b0}}, rdata_b[MEM_AW-1:0]};

    assign ra_idx  = ir.r.rd;          // a side is always rd
    assign rb_idx  = ir.r.rs;
    assign alu_op  = alu_op_t'(op_code);
    assign alu_a   = rdata_a;
    assign alu_b   = is_reg_form ? rdata_b : imm_sext;
    assign halted  = (state == S_HALT);

    always_comb begin
        case (state)
            S0: next_state = S1;
            S1: begin
                if (fetched.r.opcode == OPC_HALT)
                    next_state = S_HALT;
                else if (fetched.r.opcode == OPC_REG && fetched.r.ext == EXT_LOAD)
                    next_state = S4;
                else if (fetched.r.opcode == OPC_REG && fetched.r.ext == EXT_STOR)
                    next_state = S3;
                else
                    next_state = S2;                 // alu op, reg or imm form
            end
            S2, S3, S5: next_state = S0;
            S4:         next_state = S5;
            S_HALT:     next_state = start ? S0 : S_HALT;
            default:    next_state = S_HALT;
        endcase
    end

    always_comb begin
        core_mem  = '0;                              // no request by default
        reg_we    = 1'b0;
        reg_widx  = ir.r.rd;
        reg_wdata = alu_result;
        alu_go    = 1'b0;
        case (state)
            S0: begin
                core_mem.en   = 1'b1;                // instruction fetch
                core_mem.addr = {{(10-MEM_AW){1'b0}}, pc};
            end
            S2: begin
                alu_go = 1'b1;
                reg_we = (op_code != ALU_CMP) && (op_code != ALU_NOP); // cmp only sets flags
            end
            S3: begin
                core_mem.en    = 1'b1;
                core_mem.we    = 1'b1;
                core_mem.addr  = data_addr;
                core_mem.wdata = rdata_a;            // store rd
            end
            S4: begin
                core_mem.en   = 1'b1;
                core_mem.addr = data_addr;
            end
            S5: begin
                reg_we    = 1'b1;
                reg_wdata = mem_rdata;               // load data back into rd
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= S_HALT;
            pc    <= '0;
        end else begin
            state <= next_state;
            if (state == S_HALT && start)
                pc <= '0;                            // every run starts at word 0
            else if (state == S0)
                pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S1)
            ir <= fetched;
    end

endmodule

`default_nettype wire

/* logic/cr16_alu.sv */
// cr16 ALU and status flags
`timescale 1ns/1ns
`default_nettype none

module cr16_alu (
    input  logic              clk,
    input  logic              reset,
    input  cr16_pkg::alu_op_t alu_op,
    input  logic [15:0]       a,         // rd
    input  logic [15:0]       b,         // source, reg or imm
    input  logic              go,
    output logic [15:0]       result,
    output cr16_pkg::flags_t  flags
);
    import cr16_pkg::*;

    logic               cin;
    logic               bin;
    logic [16:0]        sum;
    logic [16:0]        diff;
    logic               add_ovf;
    logic               sub_ovf;
    logic               sh_neg;
    logic [4:0]         sh_mag;
    logic [15:0]        lsh_res;
    logic signed [15:0] ash_right;
    logic [15:0]        ash_res;

    assign cin  = (alu_op == ALU_ADDC) & flags.c;
    assign bin  = (alu_op == ALU_SUBC) & flags.c;
    assign sum  = {1'b0, a} + {1'b0, b} + {16'b0, cin};
    assign diff = {1'b0, a} - {1'b0, b} - {16'b0, bin};   // bit 16 is the borrow

    assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
    assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

    // shift count is b[4:0] as signed, negative means right
    assign sh_neg    = b[4];
    assign sh_mag    = sh_neg ? (~b[4:0] + 5'd1) : b[4:0];
    assign ash_right = $signed(a) >>> sh_mag;
    assign lsh_res   = sh_neg ? (a >> sh_mag) : (a << sh_mag);
    assign ash_res   = sh_neg ? ash_right : (a << sh_mag);

    always_comb begin
        case (alu_op)
            ALU_AND:                    result = a & b;
            ALU_OR:                     result = a | b;
            ALU_XOR:                    result = a ^ b;
            ALU_NOT:                    result = ~b;
            ALU_MOV:                    result = b;
            ALU_LSH:                    result = lsh_res;
            ALU_ASHU:                   result = ash_res;
            ALU_ADD, ALU_ADDU, ALU_ADDC: result = sum[15:0];
            ALU_SUB, ALU_SUBC, ALU_CMP: result = diff[15:0];
            default:                    result = a;        // nop keeps rd
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            flags <= '0;
        end else if (go) begin
            case (alu_op)
                ALU_ADD, ALU_ADDC: begin
                    flags.c <= sum[16];
                    flags.f <= add_ovf;
                end
                ALU_SUB, ALU_SUBC: begin
                    flags.c <= diff[16];
                    flags.f <= sub_ovf;
                end
                ALU_CMP: begin
                    flags.z <= (a == b);
                    flags.l <= (a < b);
                    flags.n <= ($signed(a) < $signed(b));
                end
                default: ;                          // addu and logic ops keep flags
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/cr16_regfile.sv */
// cr16 general register file
`timescale 1ns/1ns
`default_nettype none

module cr16_regfile (
    input  logic        clk,
    input  logic        reset,
    input  logic [3:0]  ra_idx,
    input  logic [3:0]  rb_idx,
    output logic [15:0] rdata_a,
    output logic [15:0] rdata_b,
    input  logic [3:0]  host_ra,
    output logic [15:0] host_rdata,
    input  logic        we,
    input  logic [3:0]  widx,
    input  logic [15:0] wdata
);

    logic [15:0] regs [16];

    // all three reads are combinational
    assign rdata_a    = regs[ra_idx];
    assign rdata_b    = regs[rb_idx];
    assign host_rdata = regs[host_ra];   // only valid for host while halted

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[widx] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* logic/cr16_host_mem.sv */
// cr16 APB host port and memory
`timescale 1ns/1ns
`default_nettype none

module cr16_host_mem #(
    parameter int MEM_AW = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  cr16_pkg::apb_req_t apb,
    output cr16_pkg::apb_rsp_t apb_rsp,
    input  cr16_pkg::mem_req_t core_mem,
    output logic [15:0]        mem_rdata,
    output logic               start,
    input  logic               halted,
    input  cr16_pkg::flags_t   flags,
    output logic [3:0]         host_ra,
    input  logic [15:0]        host_rdata
);
    import cr16_pkg::*;

    localparam logic [9:0] MEM_WORDS = 10'(2**MEM_AW);

    logic [15:0]       mem [2**MEM_AW];
    logic              run_q;          // core owns memory while set
    logic [9:0]        addr_q;         // address captured in setup
    logic              setup;
    logic              access;
    logic              is_mem;
    logic              is_ctrl;
    logic              is_regs;
    logic              err;
    logic              wr_ok;
    logic              start_req;
    logic              p_en;
    logic              p_we;
    logic [MEM_AW-1:0] p_addr;
    logic [15:0]       p_wdata;

    assign setup  = apb.psel & ~apb.penable;
    assign access = apb.psel & apb.penable;

    assign is_mem  = (addr_q <= MEM_TOP) && (addr_q < MEM_WORDS);
    assign is_ctrl = (addr_q == CTRL_ADDR);
    assign is_regs = (addr_q >= REGS_BASE) && (addr_q <= REGS_LAST);

    assign err = ~(is_mem | is_ctrl | is_regs)      // unmapped or unpopulated
               | (is_regs & apb.pwrite)             // registers are read only
               | ((is_mem | is_regs) & run_q);      // busy while core runs

    assign wr_ok     = access & apb.pwrite & is_mem & ~run_q;
    assign start_req = access & apb.pwrite & is_ctrl & apb.pwdata[0] & ~run_q;
    assign host_ra   = addr_q[3:0];

    // single memory port, core has it whenever running
    always_comb begin
        if (run_q) begin
            p_en    = core_mem.en;
            p_we    = core_mem.we;
            p_addr  = core_mem.addr[MEM_AW-1:0];
            p_wdata = core_mem.wdata;
        end else begin
            p_en    = setup | wr_ok;               // read ahead in setup
            p_we    = wr_ok;
            p_addr  = wr_ok ? addr_q[MEM_AW-1:0] : apb.paddr[MEM_AW-1:0];
            p_wdata = apb.pwdata;
        end
    end

    always_ff @(posedge clk) begin
        if (p_en) begin
            if (p_we)
                mem[p_addr] <= p_wdata;
            else
                mem_rdata <= mem[p_addr];          // registered read
        end
    end

    always_comb begin
        apb_rsp.prdata  = '0;
        apb_rsp.pready  = 1'b1;                    // no wait states
        apb_rsp.pslverr = access & err;
        if (access & ~err) begin
            if (is_ctrl)
                apb_rsp.prdata = {10'b0, flags.f, flags.c, flags.n, flags.l, flags.z, run_q};
            else if (is_regs)
                apb_rsp.prdata = host_rdata;
            else
                apb_rsp.prdata = mem_rdata;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            start  <= 1'b0;
            run_q  <= 1'b0;
            addr_q <= '0;
        end else begin
            start <= start_req;                    // one cycle pulse
            if (start_req)
                run_q <= 1'b1;
            else if (halted & ~start)              // core still idle during the pulse
                run_q <= 1'b0;
            if (setup)
                addr_q <= apb.paddr;
        end
    end

endmodule

`default_nettype wire

/* logic/cr16_core.sv */
// cr16 processor core top
`timescale 1ns/1ns
`default_nettype none

module cr16_core #(
    parameter int MEM_AW = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  cr16_pkg::apb_req_t apb,
    output cr16_pkg::apb_rsp_t apb_rsp
);
    import cr16_pkg::*;

    mem_req_t    core_mem;
    logic [15:0] mem_rdata;
    logic        start;
    logic        halted;
    logic [3:0]  ra_idx;
    logic [3:0]  rb_idx;
    logic [15:0] rdata_a;
    logic [15:0] rdata_b;
    logic        reg_we;
    logic [3:0]  reg_widx;
    logic [15:0] reg_wdata;
    alu_op_t     alu_op;
    logic [15:0] alu_a;
    logic [15:0] alu_b;
    logic        alu_go;
    logic [15:0] alu_result;
    flags_t      flags;
    logic [3:0]  host_ra;
    logic [15:0] host_rdata;

    cr16_control #(.MEM_AW(MEM_AW)) i_control (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .halted     (halted),
        .core_mem   (core_mem),
        .mem_rdata  (mem_rdata),
        .ra_idx     (ra_idx),
        .rb_idx     (rb_idx),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b),
        .reg_we     (reg_we),
        .reg_widx   (reg_widx),
        .reg_wdata  (reg_wdata),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_go     (alu_go),
        .alu_result (alu_result)
    );

    cr16_alu i_alu (
        .clk    (clk),
        .reset  (reset),
        .alu_op (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .go     (alu_go),
        .result (alu_result),
        .flags  (flags)
    );

    cr16_regfile i_regfile (
        .clk        (clk),
        .reset      (reset),
        .ra_idx     (ra_idx),
        .rb_idx     (rb_idx),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b),
        .host_ra    (host_ra),
        .host_rdata (host_rdata),
        .we         (reg_we),
        .widx       (reg_widx),
        .wdata      (reg_wdata)
    );

    cr16_host_mem #(.MEM_AW(MEM_AW)) i_host_mem (
        .clk        (clk),
        .reset      (reset),
        .apb        (apb),
        .apb_rsp    (apb_rsp),
        .core_mem   (core_mem),
        .mem_rdata  (mem_rdata),
        .start      (start),
        .halted     (halted),
        .flags      (flags),
        .host_ra    (host_ra),
        .host_rdata (host_rdata)
    );

endmodule

`default_nettype wire

/* sim/cr16_tb.sv */
// cr16 core directed testbench
`timescale 1ns/1ns
`default_nettype none

module cr16_tb;
    import cr16_pkg::*;

    localparam int PERIOD   = 100;
    localparam int DRV      = 5;         // input skew after the rising edge
    localparam int POLL_MAX = 500;       // CTRL polls before giving up
    localparam int XFER_MAX = 16;        // access cycles before giving up

    logic        clk;
    logic        reset;
    apb_req_t    apb;
    apb_rsp_t    apb_rsp;

    logic [31:0] lfsr;                   // random source state
    logic [15:0] m_regs [16];            // expected general registers
    flags_t      m_flags;                // expected status flags
    logic [15:0] m_mem [256];            // expected memory contents
    logic [15:0] prog [$];               // program under construction

    cr16_core #(.MEM_AW(8)) i_cr16_core (
        .clk     (clk),
        .reset   (reset),
        .apb     (apb),
        .apb_rsp (apb_rsp)
    );

    always #(PERIOD/2) clk = ~clk;

    task automatic stop_on_error();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stop_on_error();
    endtask

    task automatic check_eq(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %h actual %h",
                     $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [15:0] rand_bits(input int nbits);
        logic [15:0] v;
        int          k;
        v = '0;
        for (k = 0; k < nbits; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = {v[14:0], lfsr[0]};     // one step per bit
        end
        return v;
    endfunction

    // called and returns a little after a rising edge
    task automatic apb_xfer(input logic wr, input logic [9:0] addr, input logic [15:0] wdata,
                            output logic [15:0] rdata, output logic err);
        int waits;
        waits       = 0;
        apb.psel    = 1'b1;                // setup cycle
        apb.penable = 1'b0;
        apb.pwrite  = wr;
        apb.paddr   = addr;
        apb.pwdata  = wdata;
        @(posedge clk);
        #DRV;
        apb.penable = 1'b1;                // access cycle
        @(negedge clk);                    // response settled mid cycle
        while (apb_rsp.pready !== 1'b1) begin
            waits++;
            if (waits > XFER_MAX)
                report_error($sformatf("APB transfer to %h never completed", addr));
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #DRV;
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [9:0] addr, input logic [15:0] data, output logic err);
        logic [15:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [9:0] addr, output logic [15:0] data, output logic err);
        apb_xfer(1'b0, addr, 16'h0, data, err);
    endtask

    task automatic write_mem(input logic [9:0] addr, input logic [15:0] data);
        logic err;
        apb_write(addr, data, err);
        check_eq($sformatf("pslverr on write to %h", addr), 16'h0, {15'b0, err});
        m_mem[addr[7:0]] = data;
    endtask

    // register form keeps the op in ext and immediate form in opcode
    function automatic logic [15:0] encode(input logic imm_form, input logic [3:0] code,
                                           input logic [3:0] rd, input logic [7:0] src);
        if (imm_form)
            return {code, rd, src};
        return {OPC_REG, rd, code, src[3:0]};
    endfunction

    task automatic put_reg(input logic [3:0] code, input logic [3:0] rd, input logic [3:0] rs);
        prog.push_back(encode(1'b0, code, rd, {4'h0, rs}));
    endtask

    task automatic put_imm(input logic [3:0] code, input logic [3:0] rd, input logic [7:0] imm);
        prog.push_back(encode(1'b1, code, rd, imm));
    endtask

    task automatic put_load(input logic [3:0] rd, input logic [3:0] rs);
        prog.push_back(encode(1'b0, EXT_LOAD, rd, {4'h0, rs}));
    endtask

    task automatic put_store(input logic [3:0] rd, input logic [3:0] rs);
        prog.push_back(encode(1'b0, EXT_STOR, rd, {4'h0, rs}));
    endtask

    task automatic put_halt();
        prog.push_back({OPC_HALT, 12'h000});
    endtask

    // expected effect of one ALU operation with a as rd and b as the source
    task automatic model_alu(input logic [3:0] code, input logic [3:0] rd, input logic [15:0] b);
        logic [15:0]        a;
        logic [15:0]        r;
        logic signed [15:0] as;
        logic signed [4:0]  cnt;
        int                 n;
        int                 ua;
        int                 ub;
        int                 sa;
        int                 sb;
        int                 cin;
        int                 us;
        int                 ss;
        a   = m_regs[rd];
        as  = a;
        r   = a;
        ua  = a;
        ub  = b;
        sa  = $signed(a);
        sb  = $signed(b);
        cnt = b[4:0];
        n   = cnt;                          // signed shift count
        cin = ((code == ALU_ADDC) || (code == ALU_SUBC)) ? int'(m_flags.c) : 0;
        case (code)
            ALU_AND: r = a & b;
            ALU_OR:  r = a | b;
            ALU_XOR: r = a ^ b;
            ALU_NOT: r = ~b;
            ALU_MOV: r = b;
            ALU_LSH: begin
                if (n >= 0)
                    r = a << n;
                else
                    r = a >> (-n);
            end
            ALU_ASHU: begin
                if (n >= 0)
                    r = a << n;
                else
                    r = as >>> (-n);        // sign fill on right shift
            end
            ALU_ADD, ALU_ADDU, ALU_ADDC: begin
                us = ua + ub + cin;
                ss = sa + sb + cin;
                r  = us[15:0];
                if (code != ALU_ADDU) begin
                    m_flags.c = (us > 65535);
                    m_flags.f = (ss > 32767) || (ss < -32768);
                end
            end
            ALU_SUB, ALU_SUBC: begin
                us = ua - ub - cin;
                ss = sa - sb - cin;
                r  = us[15:0];
                m_flags.c = (us < 0);       // borrow
                m_flags.f = (ss > 32767) || (ss < -32768);
            end
            ALU_CMP: begin
                m_flags.z = (ua == ub);
                m_flags.l = (ua < ub);
                m_flags.n = (sa < sb);
            end
            default: ;
        endcase
        if ((code != ALU_CMP) && (code != ALU_NOP))
            m_regs[rd] = r;
    endtask

    task automatic model_exec(input logic [15:0] w, output logic stop);
        instr_t iw;
        iw   = w;
        stop = 1'b0;
        if (iw.r.opcode == OPC_HALT)
            stop = 1'b1;
        else if (iw.r.opcode != OPC_REG)
            model_alu(iw.i.opcode, iw.i.rd, {{8{iw.i.imm[7]}}, iw.i.imm});
        else if (iw.r.ext == EXT_LOAD)
            m_regs[iw.r.rd] = m_mem[m_regs[iw.r.rs][7:0]];
        else if (iw.r.ext == EXT_STOR)
            m_mem[m_regs[iw.r.rs][7:0]] = m_regs[iw.r.rd];
        else
            model_alu(iw.r.ext, iw.r.rd, m_regs[iw.r.rs]);
    endtask

    // program goes to word 0 and the model runs up to the first halt
    task automatic load_program();
        logic stop;
        int   k;
        for (k = 0; k < prog.size(); k++)
            write_mem(10'(k), prog[k]);
        stop = 1'b0;
        k    = 0;
        while (!stop && (k < prog.size())) begin
            model_exec(prog[k], stop);
            k++;
        end
    endtask

    task automatic start_core();
        logic err;
        apb_write(CTRL_ADDR, 16'h0001, err);
        check_eq("pslverr on CTRL start", 16'h0, {15'b0, err});
    endtask

    task automatic wait_halt();
        logic [15:0] v;
        logic        err;
        int          polls;
        polls = 0;
        v     = 16'h0001;
        while (v[0]) begin
            if (polls == POLL_MAX)
                report_error("core did not halt within the poll limit");
            apb_read(CTRL_ADDR, v, err);
            check_eq("pslverr on CTRL poll", 16'h0, {15'b0, err});
            polls++;
        end
    endtask

    task automatic run_program();
        load_program();
        start_core();
        wait_halt();
        prog.delete();
    endtask

    // all registers through REGS and the flags and running bit through CTRL
    task automatic check_state();
        logic [15:0] v;
        logic        err;
        int          k;
        for (k = 0; k < 16; k++) begin
            apb_read(REGS_BASE + 10'(k), v, err);
            check_eq("pslverr on REGS read", 16'h0, {15'b0, err});
            check_eq($sformatf("r%0d", k), m_regs[k], v);
        end
        apb_read(CTRL_ADDR, v, err);
        check_eq("pslverr on CTRL read", 16'h0, {15'b0, err});
        check_eq("CTRL", {10'b0, m_flags.f, m_flags.c, m_flags.n, m_flags.l, m_flags.z, 1'b0}, v);
    endtask

    task automatic test_host_memory();
        logic [7:0]  addrs [$];
        logic [7:0]  a;
        logic [15:0] v;
        logic        err;
        int          k;
        for (k = 0; k < 16; k++) begin
            a = 8'(rand_bits(8));
            addrs.push_back(a);
            write_mem({2'b0, a}, rand_bits(16));
        end
        for (k = 0; k < addrs.size(); k++) begin
            apb_read({2'b0, addrs[k]}, v, err);
            check_eq("pslverr on memory read", 16'h0, {15'b0, err});
            check_eq($sformatf("mem[%h]", addrs[k]), m_mem[addrs[k]], v);
        end
        apb_read(10'h100, v, err);          // inside the window but not populated
        check_eq("pslverr on unpopulated read", 16'h1, {15'b0, err});
        apb_read(10'h2A0, v, err);
        check_eq("pslverr on unmapped read", 16'h1, {15'b0, err});
        apb_read(10'h310, v, err);
        check_eq("pslverr past REGS", 16'h1, {15'b0, err});
        apb_write(10'h305, 16'h1234, err);
        check_eq("pslverr on REGS write", 16'h1, {15'b0, err});
    endtask

    task automatic test_busy();
        logic [15:0] v;
        logic        err;
        int          k;
        for (k = 0; k < 30; k++)
            put_imm(ALU_MOV, 4'(k % 8), 8'(rand_bits(8)));
        put_halt();
        load_program();
        start_core();
        apb_read(10'h010, v, err);
        check_eq("pslverr on memory read while running", 16'h1, {15'b0, err});
        apb_write(10'h011, 16'hBEEF, err);  // must not disturb the program
        check_eq("pslverr on memory write while running", 16'h1, {15'b0, err});
        apb_read(REGS_BASE, v, err);
        check_eq("pslverr on REGS read while running", 16'h1, {15'b0, err});
        apb_read(CTRL_ADDR, v, err);
        check_eq("pslverr on CTRL read while running", 16'h0, {15'b0, err});
        check_eq("CTRL running", 16'h1, {15'b0, v[0]});
        wait_halt();
        prog.delete();
        check_state();
        apb_read(10'h011, v, err);
        check_eq("pslverr on memory read after run", 16'h0, {15'b0, err});
        check_eq("mem[011]", m_mem[8'h11], v);
    endtask

    task automatic test_alu_program();
        int k;
        put_imm(ALU_MOV, 4'd1, 8'h12);
        put_imm(ALU_LSH, 4'd1, 8'h08);
        put_imm(ALU_OR, 4'd1, 8'h34);       // r1 = 0x1234
        put_imm(ALU_MOV, 4'd2, 8'hAB);      // negative immediate
        for (k = 3; k < 9; k++) begin
            put_imm(ALU_MOV, 4'(k), 8'(rand_bits(8)));
            put_imm(ALU_LSH, 4'(k), 8'h08);
            put_imm(ALU_XOR, 4'(k), 8'(rand_bits(8)));
        end
        for (k = 9; k < 16; k++)
            put_reg(ALU_MOV, 4'(k), 4'(k - 8));
        for (k = 0; k < 14; k++) begin      // nop through mov
            put_reg(4'(k), 4'(9 + k % 7), 4'(1 + (k * 3) % 8));
            if (k != 0)
                put_imm(4'(k), 4'(9 + (k + 4) % 7), 8'(rand_bits(8)));
        end
        put_halt();
        run_program();
        check_state();
    endtask

    task automatic test_flags();
        put_imm(ALU_MOV, 4'd1, 8'h05);      // equal compare
        put_imm(ALU_MOV, 4'd2, 8'h05);
        put_reg(ALU_CMP, 4'd1, 4'd2);
        put_halt();
        run_program();
        check_state();
        put_imm(ALU_MOV, 4'd1, 8'hFE);      // -2 against 3
        put_imm(ALU_CMP, 4'd1, 8'h03);
        put_halt();
        run_program();
        check_state();
        put_imm(ALU_MOV, 4'd2, 8'h03);
        put_reg(ALU_CMP, 4'd2, 4'd1);
        put_halt();
        run_program();
        check_state();
        put_imm(ALU_MOV, 4'd3, 8'hFF);      // -1 shifted right once is 0x7fff
        put_imm(ALU_LSH, 4'd3, 8'hFF);
        put_imm(ALU_ADD, 4'd3, 8'h01);      // 0x7fff + 1 overflows
        put_halt();
        run_program();
        check_state();
        put_imm(ALU_MOV, 4'd4, 8'h80);      // 0x8000 + 0x8000 carries and overflows
        put_imm(ALU_LSH, 4'd4, 8'h08);
        put_reg(ALU_ADD, 4'd4, 4'd4);
        put_halt();
        run_program();
        check_state();
        put_imm(ALU_MOV, 4'd5, 8'h10);      // carry in from the last run
        put_imm(ALU_ADDC, 4'd5, 8'h00);
        put_halt();
        run_program();
        check_state();
        put_imm(ALU_MOV, 4'd6, 8'h00);      // 0 - 0x8000 borrows and overflows
        put_reg(ALU_SUB, 4'd6, 4'd3);
        put_halt();
        run_program();
        check_state();
        put_imm(ALU_ADDU, 4'd3, 8'h7F);     // none of these touch the flags
        put_reg(ALU_AND, 4'd7, 4'd3);
        put_reg(ALU_OR, 4'd7, 4'd6);
        put_reg(ALU_XOR, 4'd8, 4'd7);
        put_reg(ALU_NOT, 4'd9, 4'd8);
        put_imm(ALU_LSH, 4'd9, 8'hFD);
        put_imm(ALU_ASHU, 4'd3, 8'hFC);
        put_reg(ALU_MOV, 4'd10, 4'd9);
        put_halt();
        run_program();
        check_state();
        put_imm(ALU_MOV, 4'd7, 8'h20);      // borrow still pending
        put_imm(ALU_SUBC, 4'd7, 8'h01);
        put_halt();
        run_program();
        check_state();
    endtask

    task automatic test_load_store();
        logic [15:0] v;
        logic        err;
        write_mem(10'h062, rand_bits(16));
        put_imm(ALU_MOV, 4'd1, 8'h60);
        put_imm(ALU_MOV, 4'd2, 8'h61);
        put_imm(ALU_MOV, 4'd3, 8'h62);
        put_store(4'd9, 4'd1);
        put_store(4'd10, 4'd2);
        put_load(4'd11, 4'd1);
        put_load(4'd12, 4'd2);
        put_load(4'd13, 4'd3);
        put_imm(ALU_MOV, 4'd4, 8'hC3);      // 0xffc3 whose low byte addresses 0xc3
        put_store(4'd1, 4'd4);
        put_load(4'd14, 4'd4);
        put_halt();
        run_program();
        check_state();
        apb_read(10'h060, v, err);
        check_eq("mem[060]", m_mem[8'h60], v);
        apb_read(10'h061, v, err);
        check_eq("mem[061]", m_mem[8'h61], v);
        apb_read(10'h0C3, v, err);
        check_eq("mem[0c3]", m_mem[8'hC3], v);
    endtask

    task automatic test_halt();
        put_imm(ALU_MOV, 4'd1, 8'h11);
        put_halt();
        put_imm(ALU_MOV, 4'd1, 8'h22);      // never reached
        put_imm(ALU_MOV, 4'd2, 8'h33);
        put_halt();
        run_program();
        check_state();
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b0;
        apb     = '0;
        lfsr    = 32'haac7_dfdd;
        m_flags = '0;
        foreach (m_regs[i])
            m_regs[i] = '0;
        repeat (5) @(posedge clk);
        #DRV;
        reset = 1'b1;
        check_state();                      // state right after reset
        test_host_memory();
        test_busy();
        test_alu_program();
        test_flags();
        test_load_store();
        test_halt();
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
common/cr16_pkg.sv
control/cr16_control.sv
logic/cr16_alu.sv
logic/cr16_regfile.sv
logic/cr16_host_mem.sv
logic/cr16_core.sv
sim/cr16_tb.sv
